//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int DATA_N = 8;
	localparam int ADDR_N = 16;

	typedef logic [DATA_N-1:0] data_t;
	typedef logic [ADDR_N-1:0] addr_t;

	// Bit positions in P
	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_R = 5;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

	typedef enum logic [7:0] {
		LDA_IMM = 8'hA9, LDA_ABS = 8'hAD,
		LDX_IMM = 8'hA2, LDX_ABS = 8'hAE,
		LDY_IMM = 8'hA0, LDY_ABS = 8'hAC,
		STA_ABS = 8'h8D, STX_ABS = 8'h8E, STY_ABS = 8'h8C,
		ADC_IMM = 8'h69, ADC_ABS = 8'h6D,
		SBC_IMM = 8'hE9, SBC_ABS = 8'hED,
		AND_IMM = 8'h29, AND_ABS = 8'h2D,
		ORA_IMM = 8'h09, ORA_ABS = 8'h0D,
		EOR_IMM = 8'h49, EOR_ABS = 8'h4D,
		INX = 8'hE8, INY = 8'hC8, DEX = 8'hCA, DEY = 8'h88,
		TAX = 8'hAA, TXA = 8'h8A,
		CLC = 8'h18, SEC = 8'h38,
		JMP_ABS = 8'h4C,
		BEQ = 8'hF0, BNE = 8'hD0,
		PHA = 8'h48, PLA = 8'h68, PHP = 8'h08,
		STP = 8'hDB
	} opcode_e;

	typedef enum logic [1:0] {MODE_IMP, MODE_IMM, MODE_ABS, MODE_REL} addr_mode_e;

	typedef enum logic [2:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_INC, ALU_DEC
	} alu_op_e;

	// ALU input A, also reused for store data
	typedef enum logic [3:0] {
		SA_ZERO, SA_A, SA_X, SA_Y, SA_SP, SA_P, SA_DL, SA_ADL, SA_PCL, SA_PCH
	} src_a_e;

	typedef enum logic [1:0] {SB_ZERO, SB_ONE, SB_DL} src_b_e;

	typedef enum logic [3:0] {
		DST_NONE, DST_A, DST_X, DST_Y, DST_SP, DST_P, DST_ADL, DST_ADH, DST_PCL, DST_PCH
	} dst_e;

	typedef enum logic [1:0] {AS_PC, AS_AD, AS_SP} addr_sel_e;

endpackage

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
	input  data_t   a_i,
	input  data_t   b_i,
	input  alu_op_e op_i,
	input  logic    cin_i,
	output data_t   y_o,
	output logic    cout_o,
	output logic    ovf_o,
	output logic    zero_o,
	output logic    sign_o
);

	data_t b_eff;
	logic [DATA_N:0] sum;

	// SBC is A + ~B + C, borrow is inverted carry
	assign b_eff = (op_i == ALU_SUB) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {{DATA_N{1'b0}}, cin_i};

	always_comb begin
		cout_o = 1'b0;
		ovf_o = 1'b0;
		unique case (op_i)
			ALU_PASS: begin
				y_o = b_i;
			end
			ALU_ADD, ALU_SUB: begin
				y_o = sum[DATA_N-1:0];
				cout_o = sum[DATA_N];
				// Operands agree in sign, result does not
				ovf_o = (a_i[DATA_N-1] == b_eff[DATA_N-1]) &&
					(sum[DATA_N-1] != a_i[DATA_N-1]);
			end
			ALU_AND: begin
				y_o = a_i & b_i;
			end
			ALU_OR: begin
				y_o = a_i | b_i;
			end
			ALU_XOR: begin
				y_o = a_i ^ b_i;
			end
			ALU_INC: begin
				y_o = a_i + 1'b1;
			end
			ALU_DEC: begin
				y_o = a_i - 1'b1;
			end
			default: begin
				y_o = b_i;
			end
		endcase
	end

	assign zero_o = (y_o == '0);
	assign sign_o = y_o[DATA_N-1];

endmodule

`default_nettype wire

//--- logic/pc.sv
`default_nettype none

module pc import cpu_pkg::*; #(
	parameter addr_t RESET_PC = 16'h0200
) (
	input  logic  clk_i,
	input  logic  arst_n_i,
	input  logic  inc_i,
	input  logic  load_i,
	input  logic  wel_i,
	input  logic  weh_i,
	input  data_t in_i,
	input  addr_t load_val_i,
	output addr_t pc_o
);

	addr_t pc_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= RESET_PC;
		end else if (load_i) begin
			pc_q <= load_val_i;
		end else if (inc_i) begin
			pc_q <= pc_q + 1'b1;
		end else begin
			if (wel_i)
				pc_q[DATA_N-1:0] <= in_i;
			if (weh_i)
				pc_q[ADDR_N-1:DATA_N] <= in_i;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- logic/idec.sv
`default_nettype none

module idec import cpu_pkg::*; (
	input  data_t      ir_i,
	output opcode_e    op_o,
	output addr_mode_e mode_o,
	output alu_op_e    alu_op_o,
	output dst_e       dst_o,
	output src_a_e     src_a_o,
	output logic       is_store_o,
	output logic       is_branch_o,
	output logic       illegal_o
);

	assign op_o = opcode_e'(ir_i);

	// Addressing mode and legality
	always_comb begin
		mode_o = MODE_IMP;
		is_branch_o = 1'b0;
		illegal_o = 1'b0;
		case (op_o)
			LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM:
				mode_o = MODE_IMM;
			LDA_ABS, LDX_ABS, LDY_ABS, STA_ABS, STX_ABS, STY_ABS, ADC_ABS, SBC_ABS,
			AND_ABS, ORA_ABS, EOR_ABS, JMP_ABS:
				mode_o = MODE_ABS;
			BEQ, BNE: begin
				mode_o = MODE_REL;
				is_branch_o = 1'b1;
			end
			INX, INY, DEX, DEY, TAX, TXA, CLC, SEC, PHA, PLA, PHP, STP:
				mode_o = MODE_IMP;
			default:
				illegal_o = 1'b1;
		endcase
	end

	// Operand source, ALU function and destination
	always_comb begin
		alu_op_o = ALU_PASS;
		dst_o = DST_NONE;
		src_a_o = SA_A;
		is_store_o = 1'b0;
		case (op_o)
			LDA_IMM, LDA_ABS, PLA: dst_o = DST_A;
			LDX_IMM, LDX_ABS: dst_o = DST_X;
			LDY_IMM, LDY_ABS: dst_o = DST_Y;
			STA_ABS: is_store_o = 1'b1;
			STX_ABS: begin
				is_store_o = 1'b1;
				src_a_o = SA_X;
			end
			STY_ABS: begin
				is_store_o = 1'b1;
				src_a_o = SA_Y;
			end
			ADC_IMM, ADC_ABS: {alu_op_o, dst_o} = {ALU_ADD, DST_A};
			SBC_IMM, SBC_ABS: {alu_op_o, dst_o} = {ALU_SUB, DST_A};
			AND_IMM, AND_ABS: {alu_op_o, dst_o} = {ALU_AND, DST_A};
			ORA_IMM, ORA_ABS: {alu_op_o, dst_o} = {ALU_OR, DST_A};
			EOR_IMM, EOR_ABS: {alu_op_o, dst_o} = {ALU_XOR, DST_A};
			INX: {alu_op_o, src_a_o, dst_o} = {ALU_INC, SA_X, DST_X};
			INY: {alu_op_o, src_a_o, dst_o} = {ALU_INC, SA_Y, DST_Y};
			DEX: {alu_op_o, src_a_o, dst_o} = {ALU_DEC, SA_X, DST_X};
			DEY: {alu_op_o, src_a_o, dst_o} = {ALU_DEC, SA_Y, DST_Y};
			// Transfers OR the source with a zero B operand
			TAX: {alu_op_o, dst_o} = {ALU_OR, DST_X};
			TXA: {alu_op_o, src_a_o, dst_o} = {ALU_OR, SA_X, DST_A};
			PHP: src_a_o = SA_P;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cpu_datapath.sv
`default_nettype none

module cpu_datapath import cpu_pkg::*; #(
	parameter addr_t RESET_PC = 16'h0200
) (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  data_t     bus_rdata_i,
	input  logic      bus_done_i,
	input  logic      ir_we_i,
	input  logic      adh_from_bus_i,
	input  logic      pc_inc_i,
	input  logic      pc_load_i,
	input  src_a_e    src_a_i,
	input  src_b_e    src_b_i,
	input  alu_op_e   alu_op_i,
	input  dst_e      dst_i,
	input  addr_sel_e addr_sel_i,
	input  logic      flags_nz_i,
	input  logic      flags_cv_i,
	input  logic      set_c_i,
	input  logic      clr_c_i,
	input  src_a_e    wdata_sel_i,
	output data_t     ir_o,
	output addr_t     bus_addr_o,
	output data_t     bus_wdata_o,
	output logic      flag_z_o
);

	data_t a_q, x_q, y_q, p_q, sp_q, dl_q, adl_q, adh_q, ir_q;
	data_t p_next, dl_cur, alu_a, alu_b, alu_y, pch_fix;
	logic alu_cin, alu_cout, alu_ovf, alu_zero, alu_sign;
	addr_t pc_q, pc_load_val;

	function automatic data_t pick_a(input src_a_e sel);
		case (sel)
			SA_A: return a_q;
			SA_X: return x_q;
			SA_Y: return y_q;
			SA_SP: return sp_q;
			SA_P: return p_q;
			SA_DL: return dl_cur;
			SA_ADL: return adl_q;
			SA_PCL: return pc_q[DATA_N-1:0];
			SA_PCH: return pc_q[ADDR_N-1:DATA_N];
			default: return '0;
		endcase
	endfunction

	// Read data is usable in the cycle it arrives
	assign dl_cur = bus_done_i ? bus_rdata_i : dl_q;
	assign ir_o = ir_we_i ? bus_rdata_i : ir_q;

	always_comb begin
		alu_a = pick_a(src_a_i);
		bus_wdata_o = pick_a(wdata_sel_i);
		case (src_b_i)
			SB_ONE: alu_b = {{(DATA_N-1){1'b0}}, 1'b1};
			SB_DL: alu_b = dl_cur;
			default: alu_b = '0;
		endcase
	end

	// Carry in only for ADC and SBC
	assign alu_cin = flags_cv_i & p_q[STATUS_C];

	alu i_alu (
		.a_i(alu_a), .b_i(alu_b), .op_i(alu_op_i), .cin_i(alu_cin),
		.y_o(alu_y), .cout_o(alu_cout), .ovf_o(alu_ovf), .zero_o(alu_zero), .sign_o(alu_sign)
	);

	// Branch target high byte, sign of offset plus low byte carry
	assign pch_fix = pc_q[ADDR_N-1:DATA_N] + {DATA_N{dl_q[DATA_N-1]}} +
		{{(DATA_N-1){1'b0}}, alu_cout};
	assign pc_load_val = adh_from_bus_i ? {bus_rdata_i, adl_q} : {pch_fix, alu_y};

	pc #(.RESET_PC(RESET_PC)) i_pc (
		.clk_i, .arst_n_i, .inc_i(pc_inc_i), .load_i(pc_load_i),
		.wel_i(dst_i == DST_PCL), .weh_i(dst_i == DST_PCH),
		.in_i(alu_y), .load_val_i(pc_load_val), .pc_o(pc_q)
	);

	always_comb begin
		p_next = p_q;
		if (dst_i == DST_P)
			p_next = alu_y;
		if (flags_nz_i) begin
			p_next[STATUS_N] = alu_sign;
			p_next[STATUS_Z] = alu_zero;
		end
		if (flags_cv_i) begin
			p_next[STATUS_C] = alu_cout;
			p_next[STATUS_V] = alu_ovf;
		end
		if (set_c_i)
			p_next[STATUS_C] = 1'b1;
		if (clr_c_i)
			p_next[STATUS_C] = 1'b0;
		p_next[STATUS_R] = 1'b1;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			p_q <= '0;
			p_q[STATUS_R] <= 1'b1;
			sp_q <= '1;
		end else begin
			p_q <= p_next;
			if (dst_i == DST_SP)
				sp_q <= alu_y;
		end
	end

	always_ff @(posedge clk_i) begin
		if (dst_i == DST_A)
			a_q <= alu_y;
		if (dst_i == DST_X)
			x_q <= alu_y;
		if (dst_i == DST_Y)
			y_q <= alu_y;
		if (dst_i == DST_ADL)
			adl_q <= alu_y;
		if (adh_from_bus_i)
			adh_q <= bus_rdata_i;
		else if (dst_i == DST_ADH)
			adh_q <= alu_y;
		if (bus_done_i)
			dl_q <= bus_rdata_i;
		if (ir_we_i)
			ir_q <= bus_rdata_i;
	end

	always_comb begin
		case (addr_sel_i)
			AS_AD: bus_addr_o = {adh_q, adl_q};
			AS_SP: bus_addr_o = {{(ADDR_N-DATA_N-1){1'b0}}, 1'b1, sp_q};
			default: bus_addr_o = pc_q;
		endcase
	end

	assign flag_z_o = p_q[STATUS_Z];

	a_pc_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(pc_inc_i && pc_load_i));

endmodule

`default_nettype wire

//--- logic/sequencer.sv
`default_nettype none

module sequencer import cpu_pkg::*; (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       bus_rdy_i,
	input  logic       flag_z_i,
	input  opcode_e    op_i,
	input  addr_mode_e mode_i,
	input  alu_op_e    alu_op_i,
	input  dst_e       dst_i,
	input  src_a_e     src_a_i,
	input  logic       is_store_i,
	input  logic       is_branch_i,
	input  logic       illegal_i,
	output logic       bus_req_o,
	output logic       bus_we_o,
	output logic       bus_done_o,
	output logic       ir_we_o,
	output logic       adh_from_bus_o,
	output logic       pc_inc_o,
	output logic       pc_load_o,
	output logic       flags_nz_o,
	output logic       flags_cv_o,
	output logic       set_c_o,
	output logic       clr_c_o,
	output logic       dbg_o,
	output src_a_e     src_a_o,
	output src_b_e     src_b_o,
	output alu_op_e    alu_op_o,
	output dst_e       dst_o,
	output addr_sel_e  addr_sel_o,
	output src_a_e     wdata_sel_o
);

	typedef enum logic [3:0] {
		S_FETCH, S_OPL, S_OPH, S_MEM, S_EXEC, S_BRANCH, S_PUSH, S_PULL, S_HALT
	} state_e;

	state_e state_q, state_d;
	logic run_q, adv, apply, taken;

	assign taken = (op_i == BEQ) ? flag_z_i : !flag_z_i;
	assign bus_done_o = bus_req_o & bus_rdy_i;
	assign dbg_o = (state_q == S_HALT);
	assign wdata_sel_o = src_a_i;

	always_comb begin
		state_d = state_q;
		{bus_req_o, bus_we_o, ir_we_o, adh_from_bus_o, pc_inc_o, pc_load_o} = '0;
		{flags_nz_o, flags_cv_o, set_c_o, clr_c_o, apply} = '0;
		addr_sel_o = AS_PC;
		src_a_o = SA_ZERO;
		src_b_o = SB_DL;
		alu_op_o = ALU_PASS;
		dst_o = DST_NONE;
		unique case (state_q)
			S_FETCH: if (run_q) begin
				// Decode sees the opcode on the bus as it arrives
				{bus_req_o, ir_we_o, pc_inc_o} = '1;
				if (mode_i != MODE_IMP)
					state_d = S_OPL;
				else if (op_i == PHA || op_i == PHP)
					state_d = S_PUSH;
				else if (op_i == PLA)
					state_d = S_PULL;
				else
					state_d = S_EXEC;
			end
			S_OPL: begin
				{bus_req_o, pc_inc_o} = '1;
				if (is_branch_i) begin
					state_d = taken ? S_BRANCH : S_FETCH;
				end else if (mode_i == MODE_IMM) begin
					apply = 1'b1;
					state_d = S_FETCH;
				end else begin
					dst_o = DST_ADL;
					state_d = S_OPH;
				end
			end
			S_OPH: begin
				{bus_req_o, adh_from_bus_o} = '1;
				pc_load_o = (op_i == JMP_ABS);
				pc_inc_o = (op_i != JMP_ABS);
				state_d = (op_i == JMP_ABS) ? S_FETCH : S_MEM;
			end
			S_MEM: begin
				bus_req_o = 1'b1;
				bus_we_o = is_store_i;
				addr_sel_o = (op_i == PLA) ? AS_SP : AS_AD;
				apply = !is_store_i;
				state_d = S_FETCH;
			end
			S_EXEC: begin
				apply = 1'b1;
				state_d = (illegal_i || op_i == STP) ? S_HALT : S_FETCH;
			end
			S_BRANCH: begin
				{src_a_o, alu_op_o, pc_load_o} = {SA_PCL, ALU_ADD, 1'b1};
				state_d = S_FETCH;
			end
			S_PUSH: begin
				{bus_req_o, bus_we_o, addr_sel_o} = {2'b11, AS_SP};
				{src_a_o, alu_op_o, dst_o} = {SA_SP, ALU_DEC, DST_SP};
				state_d = S_FETCH;
			end
			S_PULL: begin
				{src_a_o, alu_op_o, dst_o} = {SA_SP, ALU_INC, DST_SP};
				state_d = S_MEM;
			end
			default: ;
		endcase
		if (apply) begin
			{src_a_o, alu_op_o, dst_o} = {src_a_i, alu_op_i, dst_i};
			src_b_o = (state_q == S_EXEC) ? SB_ZERO : SB_DL;
			flags_nz_o = dst_i inside {DST_A, DST_X, DST_Y};
			flags_cv_o = alu_op_i inside {ALU_ADD, ALU_SUB};
			set_c_o = (op_i == SEC);
			clr_c_o = (op_i == CLC);
		end
		// Nothing commits until the access completes
		adv = !bus_req_o || bus_rdy_i;
		if (!adv) begin
			{ir_we_o, adh_from_bus_o, pc_inc_o, pc_load_o} = '0;
			{flags_nz_o, flags_cv_o, set_c_o, clr_c_o} = '0;
			dst_o = DST_NONE;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_FETCH;
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (adv)
				state_q <= state_d;
		end
	end

	a_bus_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		bus_req_o && !bus_rdy_i |=> bus_req_o && $stable(bus_we_o) && $stable(addr_sel_o));

	a_halt_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		dbg_o |-> !bus_req_o);

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter addr_t RESET_PC = 16'h0200
) (
	input  logic  clk_i,
	input  logic  arst_n_i,
	input  logic  bus_rdy_i,
	input  data_t bus_rdata_i,
	output logic  bus_req_o,
	output logic  bus_we_o,
	output logic  dbg_o,
	output addr_t bus_addr_o,
	output data_t bus_wdata_o
);

	data_t ir;
	opcode_e op;
	addr_mode_e mode;
	alu_op_e dec_alu_op, alu_op;
	dst_e dec_dst, dst;
	src_a_e dec_src_a, src_a, wdata_sel;
	src_b_e src_b;
	addr_sel_e addr_sel;
	logic is_store, is_branch, illegal, flag_z;
	logic bus_done, ir_we, adh_from_bus, pc_inc, pc_load;
	logic flags_nz, flags_cv, set_c, clr_c;

	cpu_datapath #(.RESET_PC(RESET_PC)) i_datapath (
		.clk_i, .arst_n_i, .bus_rdata_i, .bus_done_i(bus_done), .ir_we_i(ir_we),
		.adh_from_bus_i(adh_from_bus), .pc_inc_i(pc_inc), .pc_load_i(pc_load),
		.src_a_i(src_a), .src_b_i(src_b), .alu_op_i(alu_op), .dst_i(dst),
		.addr_sel_i(addr_sel), .flags_nz_i(flags_nz), .flags_cv_i(flags_cv),
		.set_c_i(set_c), .clr_c_i(clr_c), .wdata_sel_i(wdata_sel),
		.ir_o(ir), .bus_addr_o, .bus_wdata_o, .flag_z_o(flag_z)
	);

	idec i_idec (
		.ir_i(ir), .op_o(op), .mode_o(mode), .alu_op_o(dec_alu_op), .dst_o(dec_dst),
		.src_a_o(dec_src_a), .is_store_o(is_store), .is_branch_o(is_branch),
		.illegal_o(illegal)
	);

	sequencer i_sequencer (
		.clk_i, .arst_n_i, .bus_rdy_i, .flag_z_i(flag_z), .op_i(op), .mode_i(mode),
		.alu_op_i(dec_alu_op), .dst_i(dec_dst), .src_a_i(dec_src_a),
		.is_store_i(is_store), .is_branch_i(is_branch), .illegal_i(illegal),
		.bus_req_o, .bus_we_o, .bus_done_o(bus_done), .ir_we_o(ir_we),
		.adh_from_bus_o(adh_from_bus), .pc_inc_o(pc_inc), .pc_load_o(pc_load),
		.flags_nz_o(flags_nz), .flags_cv_o(flags_cv), .set_c_o(set_c), .clr_c_o(clr_c),
		.dbg_o, .src_a_o(src_a), .src_b_o(src_b), .alu_op_o(alu_op), .dst_o(dst),
		.addr_sel_o(addr_sel), .wdata_sel_o(wdata_sel)
	);

endmodule

`default_nettype wire

//--- bench/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// Instruction-level model of the core. Runs from start until STP or an illegal
// opcode, collects every write in order and returns the address of the halting opcode
function automatic addr_t predict_writes(input data_t img [0:65535], input addr_t start,
		output addr_t wr_addr [$], output data_t wr_data [$]);
	data_t mem [0:65535];
	data_t a, x, y, sp, m, res;
	logic n, v, z, c, nz;
	addr_t pc, ea, at;
	int diff;
	int step;
	mem = img;
	a = 8'h00;
	x = 8'h00;
	y = 8'h00;
	sp = 8'hFF;
	{n, v, z, c} = 4'b0000;
	pc = start;
	at = start;
	wr_addr.delete();
	wr_data.delete();
	for (step = 0; step < 4096; step++) begin
		at = pc;
		pc = pc + 16'h0001;
		m = 8'h00;
		ea = 16'h0000;
		// Operand fetch by addressing mode
		case (mem[at])
			LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM,
			BEQ, BNE: begin
				m = mem[pc];
				pc = pc + 16'h0001;
			end
			LDA_ABS, LDX_ABS, LDY_ABS, STA_ABS, STX_ABS, STY_ABS, ADC_ABS, SBC_ABS,
			AND_ABS, ORA_ABS, EOR_ABS, JMP_ABS: begin
				ea = {mem[pc + 16'h0001], mem[pc]};
				pc = pc + 16'h0002;
				m = mem[ea];
			end
			default: ;
		endcase
		res = m;
		nz = 1'b1;
		case (mem[at])
			LDA_IMM, LDA_ABS: a = m;
			LDX_IMM, LDX_ABS: x = m;
			LDY_IMM, LDY_ABS: y = m;
			ADC_IMM, ADC_ABS: begin
				{c, res} = {1'b0, a} + {1'b0, m} + c;
				v = (~(a ^ m) & (a ^ res) & 8'h80) != 8'h00;
				a = res;
			end
			SBC_IMM, SBC_ABS: begin
				// Carry clear means a borrow comes in
				diff = int'(a) - int'(m) - (c ? 0 : 1);
				res = diff[7:0];
				c = (diff >= 0);
				v = ((a ^ m) & (a ^ res) & 8'h80) != 8'h00;
				a = res;
			end
			AND_IMM, AND_ABS: begin
				a = a & m;
				res = a;
			end
			ORA_IMM, ORA_ABS: begin
				a = a | m;
				res = a;
			end
			EOR_IMM, EOR_ABS: begin
				a = a ^ m;
				res = a;
			end
			INX: begin
				x = x + 8'h01;
				res = x;
			end
			INY: begin
				y = y + 8'h01;
				res = y;
			end
			DEX: begin
				x = x - 8'h01;
				res = x;
			end
			DEY: begin
				y = y - 8'h01;
				res = y;
			end
			TAX: begin
				x = a;
				res = x;
			end
			TXA: begin
				a = x;
				res = a;
			end
			CLC: {c, nz} = 2'b00;
			SEC: {c, nz} = 2'b10;
			STA_ABS, STX_ABS, STY_ABS: begin
				res = (mem[at] == STA_ABS) ? a : (mem[at] == STX_ABS) ? x : y;
				mem[ea] = res;
				wr_addr.push_back(ea);
				wr_data.push_back(res);
				nz = 1'b0;
			end
			JMP_ABS: begin
				pc = ea;
				nz = 1'b0;
			end
			BEQ, BNE: begin
				if (z == (mem[at] == BEQ))
					pc = pc + {{8{m[7]}}, m};
				nz = 1'b0;
			end
			PHA, PHP: begin
				// B, D and I do not exist here and push as zero
				res = (mem[at] == PHA) ? a : {n, v, 1'b1, 3'b000, z, c};
				ea = {8'h01, sp};
				mem[ea] = res;
				wr_addr.push_back(ea);
				wr_data.push_back(res);
				sp = sp - 8'h01;
				nz = 1'b0;
			end
			PLA: begin
				sp = sp + 8'h01;
				a = mem[{8'h01, sp}];
				res = a;
			end
			default:
				return at;
		endcase
		if (nz) begin
			n = res[7];
			z = (res == 8'h00);
		end
	end
	return at;
endfunction

`endif

//--- bench/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam addr_t RESET_ADDR = 16'h0200;
	localparam int HALT_WATCH = 20;

	logic clk_i;
	logic arst_n_i;
	logic bus_rdy_i;
	data_t bus_rdata_i;
	logic bus_req_o;
	logic bus_we_o;
	logic dbg_o;
	addr_t bus_addr_o;
	data_t bus_wdata_o;

	data_t mem [0:65535];
	addr_t exp_addr [$];
	data_t exp_data [$];
	addr_t stp_addr, last_rd_addr, asm_pc;
	int seed;
	int n_instr, wr_count, wait_left, cycles, limit;
	int err_value, err_other;

	`include "cpu_ref.svh"

	cpu #(.RESET_PC(RESET_ADDR)) i_cpu (
		.clk_i, .arst_n_i, .bus_rdy_i, .bus_rdata_i, .bus_req_o, .bus_we_o, .dbg_o,
		.bus_addr_o, .bus_wdata_o
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, got %h", name, exp, act);
			err_value++;
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, got %h", name, exp, act);
			err_value++;
		end
	endtask

	function automatic data_t rand_byte();
		return data_t'($random(seed));
	endfunction

	task automatic fill_memory();
		addr_t ad;
		for (int i = 0; i < 65536; i++) begin
			ad = addr_t'(i);
			mem[i] = ad[15:8] ^ {ad[6:0], ad[7]} ^ 8'h5A;
		end
	endtask

	task automatic emit_byte(input data_t b);
		mem[asm_pc] = b;
		asm_pc = asm_pc + 16'h0001;
	endtask

	task automatic put_imp(input opcode_e op);
		emit_byte(op);
		n_instr++;
	endtask

	task automatic put_imm(input opcode_e op, input data_t b);
		emit_byte(op);
		emit_byte(b);
		n_instr++;
	endtask

	task automatic put_abs(input opcode_e op, input addr_t ad);
		emit_byte(op);
		emit_byte(ad[7:0]);
		emit_byte(ad[15:8]);
		n_instr++;
	endtask

	task automatic build_program();
		asm_pc = RESET_ADDR;
		// Loads and stores
		put_imm(LDA_IMM, rand_byte());
		put_imm(LDX_IMM, rand_byte());
		put_imm(LDY_IMM, rand_byte());
		put_abs(STA_ABS, 16'h0300);
		put_abs(STX_ABS, 16'h0301);
		put_abs(STY_ABS, 16'h0302);
		put_abs(LDA_ABS, 16'h0480);
		put_abs(LDX_ABS, 16'h0301);
		put_abs(LDY_ABS, 16'h0481);
		put_abs(STA_ABS, 16'h0303);
		put_abs(STX_ABS, 16'h0304);
		put_abs(STY_ABS, 16'h0305);
		// ALU chains with flags pushed after each
		put_imp(CLC);
		put_imm(ADC_IMM, rand_byte());
		put_abs(ADC_ABS, 16'h0300);
		put_abs(STA_ABS, 16'h0306);
		put_imp(PHP);
		put_imp(SEC);
		put_imm(SBC_IMM, rand_byte());
		put_abs(SBC_ABS, 16'h0481);
		put_abs(STA_ABS, 16'h0307);
		put_imp(PHP);
		put_imm(AND_IMM, rand_byte());
		put_abs(ORA_ABS, 16'h0302);
		put_abs(AND_ABS, 16'h0481);
		put_imm(ORA_IMM, rand_byte());
		put_abs(EOR_ABS, 16'h0300);
		put_imm(EOR_IMM, rand_byte());
		put_abs(STA_ABS, 16'h0308);
		put_imp(PHP);
		put_imp(TAX);
		put_imp(INX);
		put_imp(DEY);
		put_imp(INY);
		put_imp(INY);
		put_imp(TXA);
		put_imp(DEX);
		put_abs(STA_ABS, 16'h0309);
		put_abs(STX_ABS, 16'h030A);
		put_abs(STY_ABS, 16'h030B);
		// Branches skip a 3-byte store when taken
		put_imm(LDA_IMM, 8'h00);
		put_imm(BEQ, 8'h03);
		put_abs(STA_ABS, 16'h0310);
		put_imm(BNE, 8'h03);
		put_abs(STA_ABS, 16'h0311);
		put_imm(LDX_IMM, 8'h01);
		put_imm(BEQ, 8'h03);
		put_abs(STX_ABS, 16'h0312);
		put_imm(BNE, 8'h03);
		put_abs(STX_ABS, 16'h0313);
		put_imm(LDA_IMM, rand_byte());
		put_imm(EOR_IMM, rand_byte());
		put_imm(BEQ, 8'h03);
		put_abs(STA_ABS, 16'h0314);
		put_abs(JMP_ABS, 16'h05EE);
		put_abs(STA_ABS, 16'h0315);
		// Branch target crosses into page 06
		asm_pc = 16'h05EE;
		put_imm(LDX_IMM, 8'h05);
		put_imm(BNE, 8'h10);
		put_abs(STX_ABS, 16'h0316);
		asm_pc = 16'h0602;
		// Counted loop with a backward branch
		put_imm(LDY_IMM, 8'h03);
		put_abs(STY_ABS, 16'h0320);
		put_imp(DEY);
		put_imm(BNE, 8'hFA);
		// Stack round trip
		put_imm(LDA_IMM, rand_byte());
		put_imp(PHA);
		put_imm(LDA_IMM, rand_byte());
		put_imp(PHA);
		put_imp(PHP);
		put_imp(PLA);
		put_abs(STA_ABS, 16'h0330);
		put_imp(PLA);
		put_abs(STA_ABS, 16'h0331);
		put_imp(PLA);
		put_abs(STA_ABS, 16'h0332);
		put_imp(STP);
	endtask

	// Memory with 0 to 3 wait cycles per access
	always @(posedge clk_i) begin
		if (!arst_n_i) begin
			bus_rdy_i <= 1'b0;
			wait_left = 0;
		end else if (bus_req_o && bus_rdy_i) begin
			if (bus_we_o)
				mem[bus_addr_o] <= bus_wdata_o;
			bus_rdy_i <= 1'b0;
			wait_left = {$random(seed)} % 4;
		end else if (bus_req_o) begin
			if (wait_left == 0) begin
				bus_rdata_i <= mem[bus_addr_o];
				bus_rdy_i <= 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	// Compare each completed write with the model's list
	always @(posedge clk_i) begin
		if (!arst_n_i) begin
			if (bus_req_o) begin
				$display("Bus request raised while reset is asserted at %0t", $time);
				err_other++;
			end
		end else begin
			if (dbg_o && bus_req_o) begin
				$display("Bus request to %h after the core halted", bus_addr_o);
				err_other++;
			end
			if (bus_req_o && bus_rdy_i && bus_we_o) begin
				if (wr_count < exp_addr.size()) begin
					check_addr("bus_addr_o", exp_addr[wr_count], bus_addr_o);
					check_data("bus_wdata_o", exp_data[wr_count], bus_wdata_o);
				end else begin
					$display("Write to %h is beyond the writes the model expects", bus_addr_o);
					err_other++;
				end
				wr_count++;
			end else if (bus_req_o && bus_rdy_i) begin
				last_rd_addr = bus_addr_o;
			end
		end
	end

	initial begin
		arst_n_i = 1'b0;
		bus_rdy_i = 1'b0;
		bus_rdata_i = 8'h00;
		seed = 32'hc834d2f7;
		n_instr = 0;
		wr_count = 0;
		wait_left = 0;
		cycles = 0;
		err_value = 0;
		err_other = 0;
		last_rd_addr = 16'h0000;
		fill_memory();
		build_program();
		stp_addr = predict_writes(mem, RESET_ADDR, exp_addr, exp_data);
		limit = 24 * n_instr + 200;
		repeat (10) @(posedge clk_i);
		arst_n_i <= 1'b1;
		while (!dbg_o && cycles < limit) begin
			@(negedge clk_i);
			cycles++;
		end
		if (!dbg_o) begin
			$display("Timeout after %0d cycles, the core never halted", cycles);
			err_other++;
		end else begin
			// Bus must stay idle after the halt
			repeat (HALT_WATCH) @(negedge clk_i);
			if (wr_count != exp_addr.size()) begin
				$display("Core made %0d writes, the model expects %0d", wr_count,
					exp_addr.size());
				err_other++;
			end
			check_addr("bus_addr_o at halting fetch", stp_addr, last_rd_addr);
		end
		$display("Writes %0d, value errors %0d, other errors %0d", wr_count, err_value,
			err_other);
		if (err_value == 0 && err_other == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
logic/cpu_pkg.sv
logic/alu.sv
logic/pc.sv
logic/idec.sv
logic/cpu_datapath.sv
logic/sequencer.sv
logic/cpu.sv
bench/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu6502_lite

sources:
  - logic/cpu_pkg.sv
  - logic/alu.sv
  - logic/pc.sv
  - logic/idec.sv
  - logic/cpu_datapath.sv
  - logic/sequencer.sv
  - logic/cpu.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_cpu.sv
